/* fc_subsystem.f */
+incdir+hw
hw/fc_isa_pkg.sv
hw/fc_irq_pkg.sv
hw/fc_irq_capture.sv
hw/fc_fetch.sv
hw/fc_execute.sv
hw/fc_subsystem.sv
verification/tb_clk_gen.sv
verification/tb_fc_subsystem.sv

/* hw/fc_execute.sv */
// ****************************
// Execute stage
// Accumulator core with data port, interrupts and debug halt
// ****************************
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_execute
  import fc_isa_pkg::*, fc_irq_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_en_i,
  input  logic [`FC_XLEN-1:0]    boot_addr_i,
  input  logic                   debug_req_i,
  input  logic [`FC_NUM_IRQ-1:0] irq_pending_i,
  input  logic                   instr_valid_i,
  input  fc_instr_t              instr_word_i,
  input  logic [`FC_XLEN-1:0]    instr_pc_i,
  output logic                   instr_take_o,
  output logic                   redirect_o,
  output logic [`FC_XLEN-1:0]    redirect_pc_o,
  output logic                   fetch_stall_o,
  output logic                   start_o,
  output logic [`FC_XLEN-1:0]    start_pc_o,
  output logic                   irq_ack_o,
  output fc_irq_id_t             irq_ack_id_o,
  output logic                   stoptimer_o,
  output logic                   l2_data_req_o,
  output logic [`FC_XLEN-1:0]    l2_data_addr_o,
  output logic                   l2_data_we_o,
  output logic [`FC_XLEN-1:0]    l2_data_wdata_o,
  input  logic                   l2_data_gnt_i,
  input  logic                   l2_data_rvalid_i,
  input  logic [`FC_XLEN-1:0]    l2_data_rdata_i
);

  localparam int IMM_W = $bits(fc_imm_t);

  fc_exec_state_e      state_q, state_d;
  logic [`FC_XLEN-1:0] acc_q, acc_d;
  logic [`FC_XLEN-1:0] next_pc_q, next_pc_d;
  logic [`FC_XLEN-1:0] epc_q, epc_d;
  logic [`FC_XLEN-1:0] boot_q;
  logic                in_handler_q, in_handler_d;
  logic [`FC_XLEN-1:0] data_addr_q;
  logic [`FC_XLEN-1:0] data_wdata_q;
  logic                data_we_q;
  logic                mem_start;
  fc_irq_id_t          irq_id;
  logic [`FC_XLEN-1:0] imm_sext;
  logic [`FC_XLEN-1:0] imm_word;
  logic [`FC_XLEN-1:0] vector_pc;

  // Lowest pending line wins
  always_comb begin
    irq_id = '0;
    for (int i = `FC_NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_pending_i[i]) begin
        irq_id = fc_irq_id_t'(i);
      end
    end
  end

  assign imm_sext  = {{(`FC_XLEN - IMM_W){instr_word_i.imm[IMM_W-1]}}, instr_word_i.imm};
  assign imm_word  = {{(`FC_XLEN - IMM_W - 2){1'b0}}, instr_word_i.imm, 2'b00};
  assign vector_pc = boot_q + `FC_VECTOR_OFFSET + `FC_XLEN'({irq_id, 2'b00});

  // ****************************
  // Control FSM
  // ****************************
  always_comb begin
    state_d       = state_q;
    acc_d         = acc_q;
    next_pc_d     = next_pc_q;
    epc_d         = epc_q;
    in_handler_d  = in_handler_q;
    instr_take_o  = 1'b0;
    redirect_o    = 1'b0;
    redirect_pc_o = vector_pc;
    irq_ack_o     = 1'b0;
    start_o       = 1'b0;
    mem_start     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (fetch_en_i) begin
          start_o   = 1'b1;
          next_pc_d = boot_addr_i;
          state_d   = ST_RUN;
        end
      end
      ST_RUN: begin
        // Instruction boundary: debug first, then interrupts
        if (debug_req_i) begin
          state_d = ST_HALT;
        end else if (!in_handler_q && (|irq_pending_i)) begin
          irq_ack_o    = 1'b1;
          redirect_o   = 1'b1;
          epc_d        = next_pc_q;
          next_pc_d    = vector_pc;
          in_handler_d = 1'b1;
        end else if (instr_valid_i) begin
          instr_take_o = 1'b1;
          next_pc_d    = instr_pc_i + `FC_XLEN'(4);
          case (instr_word_i.opcode)
            OP_LOADI: acc_d = imm_sext;
            OP_ADDI:  acc_d = acc_q + imm_sext;
            OP_LOAD, OP_STORE: begin
              mem_start = 1'b1;
              state_d   = ST_MEM_REQ;
            end
            OP_JUMP: begin
              redirect_o    = 1'b1;
              redirect_pc_o = imm_word;
              next_pc_d     = imm_word;
            end
            OP_WFI: state_d = ST_SLEEP;
            OP_MRET: begin
              redirect_o    = 1'b1;
              redirect_pc_o = epc_q;
              next_pc_d     = epc_q;
              in_handler_d  = 1'b0;
            end
            // NOP and unused codes just retire
            default: ;
          endcase
        end
      end
      ST_MEM_REQ: begin
        if (l2_data_gnt_i) begin
          state_d = ST_MEM_WAIT;
        end
      end
      ST_MEM_WAIT: begin
        if (l2_data_rvalid_i) begin
          if (!data_we_q) begin
            acc_d = l2_data_rdata_i;
          end
          state_d = ST_RUN;
        end
      end
      ST_SLEEP: begin
        if ((|irq_pending_i) || debug_req_i) begin
          state_d = ST_RUN;
        end
      end
      ST_HALT: begin
        if (!debug_req_i) begin
          state_d = ST_RUN;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      acc_q        <= '0;
      next_pc_q    <= '0;
      epc_q        <= '0;
      boot_q       <= '0;
      in_handler_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      acc_q        <= acc_d;
      next_pc_q    <= next_pc_d;
      epc_q        <= epc_d;
      in_handler_q <= in_handler_d;
      if (start_o) begin
        boot_q <= boot_addr_i;
      end
    end
  end

  // Data transfer fields, loaded when a LOAD or STORE retires
  always_ff @(posedge clk_i) begin
    if (mem_start) begin
      data_addr_q  <= imm_word;
      data_we_q    <= (instr_word_i.opcode == OP_STORE);
      data_wdata_q <= acc_q;
    end
  end

  assign start_pc_o      = boot_addr_i;
  assign irq_ack_id_o    = irq_id;
  assign fetch_stall_o   = (state_q == ST_SLEEP) || (state_q == ST_HALT);
  assign stoptimer_o     = (state_q == ST_HALT);
  assign l2_data_req_o   = (state_q == ST_MEM_REQ);
  assign l2_data_addr_o  = data_addr_q;
  assign l2_data_we_o    = data_we_q;
  assign l2_data_wdata_o = data_wdata_q;

  // After a grant no new request until the response is back
  a_one_data_txn : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    l2_data_req_o && l2_data_gnt_i |=> !l2_data_req_o until_with l2_data_rvalid_i
  ) else $error("second data request before rvalid");

endmodule

/* hw/fc_fetch.sv */
// ****************************
// Instruction fetch stage
// Prefetches words over the L2 instruction port
// ****************************
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_fetch
  import fc_isa_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic [`FC_XLEN-1:0] start_pc_i,
  input  logic                redirect_i,
  input  logic [`FC_XLEN-1:0] redirect_pc_i,
  input  logic                stall_i,
  input  logic                instr_take_i,
  output logic                instr_valid_o,
  output fc_instr_t           instr_word_o,
  output logic [`FC_XLEN-1:0] instr_pc_o,
  output logic                l2_instr_req_o,
  output logic [`FC_XLEN-1:0] l2_instr_addr_o,
  input  logic                l2_instr_gnt_i,
  input  logic                l2_instr_rvalid_i,
  input  logic [`FC_XLEN-1:0] l2_instr_rdata_i
);

  localparam int DEPTH = `FC_FETCH_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic                running_q;
  logic                req_q;
  logic                outstanding_q;
  logic                discard_q;
  logic [`FC_XLEN-1:0] fetch_pc_q;
  logic [`FC_XLEN-1:0] req_addr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [CNT_W-1:0]    count_q;
  fc_instr_t           word_q [DEPTH];
  logic [`FC_XLEN-1:0] pc_q [DEPTH];
  logic                issue;
  logic                push;
  logic                pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // New request only with a free slot and nothing in flight
  assign issue = running_q && !req_q && !outstanding_q && !stall_i && !redirect_i &&
                 !start_i && (count_q < CNT_W'(DEPTH));
  assign push  = l2_instr_rvalid_i && !discard_q && !redirect_i;
  assign pop   = instr_take_i && instr_valid_o && !redirect_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q     <= 1'b0;
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      fetch_pc_q    <= '0;
      rd_ptr_q      <= '0;
      wr_ptr_q      <= '0;
      count_q       <= '0;
    end else begin
      if (start_i) begin
        running_q  <= 1'b1;
        fetch_pc_q <= start_pc_i;
      end else if (redirect_i) begin
        fetch_pc_q <= redirect_pc_i;
      end else if (issue) begin
        fetch_pc_q <= fetch_pc_q + `FC_XLEN'(4);
      end
      if (issue) begin
        req_q <= 1'b1;
      end else if (req_q && l2_instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && l2_instr_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (l2_instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
      // Whatever is still in flight at a redirect belongs to the old path
      if (redirect_i) begin
        discard_q <= req_q || (outstanding_q && !l2_instr_rvalid_i);
      end else if (l2_instr_rvalid_i) begin
        discard_q <= 1'b0;
      end
      if (redirect_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= next_ptr(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= next_ptr(rd_ptr_q);
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // Buffer contents and request address
  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_addr_q <= fetch_pc_q;
    end
    if (push) begin
      word_q[wr_ptr_q] <= fc_instr_t'(l2_instr_rdata_i);
      pc_q[wr_ptr_q]   <= req_addr_q;
    end
  end

  assign instr_valid_o   = (count_q != '0);
  assign instr_word_o    = word_q[rd_ptr_q];
  assign instr_pc_o      = pc_q[rd_ptr_q];
  assign l2_instr_req_o  = req_q;
  assign l2_instr_addr_o = req_addr_q;

  // Request and address hold until the slave grants
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    l2_instr_req_o && !l2_instr_gnt_i |=> l2_instr_req_o && $stable(l2_instr_addr_o)
  ) else $error("instr req dropped or changed before gnt");

endmodule

/* hw/fc_irq_capture.sv */
// ****************************
// Interrupt capture
// Synchronizes event lines and keeps sticky pending bits
// ****************************
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_irq_capture
  import fc_irq_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FC_NUM_IRQ-1:0] events_i,
  input  logic                   irq_ack_i,
  input  fc_irq_id_t             irq_ack_id_i,
  output logic [`FC_NUM_IRQ-1:0] irq_pending_o
);

  logic [`FC_NUM_IRQ-1:0] sync_q;
  logic [`FC_NUM_IRQ-1:0] sync_qq;
  logic [`FC_NUM_IRQ-1:0] prev_q;
  logic [`FC_NUM_IRQ-1:0] rise;
  logic [`FC_NUM_IRQ-1:0] pending_q;

  // Rising edge on the synchronized lines
  assign rise = sync_qq & ~prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q    <= '0;
      sync_qq   <= '0;
      prev_q    <= '0;
      pending_q <= '0;
    end else begin
      sync_q  <= events_i;
      sync_qq <= sync_q;
      prev_q  <= sync_qq;
      for (int i = 0; i < `FC_NUM_IRQ; i++) begin
        if (i == `FC_LEVEL_IRQ) begin
          // Level line follows its input, ack has no effect
          pending_q[i] <= sync_qq[i];
        end else if (irq_ack_i && (irq_ack_id_i == fc_irq_id_t'(i))) begin
          pending_q[i] <= 1'b0;
        end else begin
          pending_q[i] <= pending_q[i] | rise[i];
        end
      end
    end
  end

  assign irq_pending_o = pending_q;

  // ****************************
  // Checks
  // ****************************
  // The core may only acknowledge a line that is pending
  a_ack_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |-> irq_pending_o[irq_ack_id_i]
  ) else $error("irq ack for id %0d without pending bit", irq_ack_id_i);

endmodule

/* hw/fc_irq_pkg.sv */
// ****************************
// Interrupt and execute control types
// ****************************
`include "fc_settings.svh"

package fc_irq_pkg;

  // One id per interrupt line
  typedef logic [$clog2(`FC_NUM_IRQ)-1:0] fc_irq_id_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RUN,
    ST_MEM_REQ,
    ST_MEM_WAIT,
    ST_SLEEP,
    ST_HALT
  } fc_exec_state_e;

endpackage

/* hw/fc_isa_pkg.sv */
// ****************************
// Accumulator ISA encodings
// Opcodes and instruction word layout
// ****************************
package fc_isa_pkg;

  // Opcode in bits 31:28 of each instruction word
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_LOADI = 4'h1,
    OP_ADDI  = 4'h2,
    OP_LOAD  = 4'h3,
    OP_STORE = 4'h4,
    OP_JUMP  = 4'h5,
    OP_WFI   = 4'h6,
    OP_MRET  = 4'h7
  } fc_opcode_e;

  // Value, word address or jump target depending on the opcode
  typedef logic [27:0] fc_imm_t;

  typedef struct packed {
    fc_opcode_e opcode;
    fc_imm_t    imm;
  } fc_instr_t;

endpackage

/* hw/fc_settings.svh */
// ****************************
// Fabric controller settings
// Widths, interrupt map and fetch sizing
// ****************************
`ifndef FC_SETTINGS_SVH
`define FC_SETTINGS_SVH

// Data and address width
`define FC_XLEN 32

// Interrupt lines into the controller
`define FC_NUM_IRQ 32

// Event generator line, sampled as a level
`define FC_LEVEL_IRQ 11

// Vector table sits above the boot address
`define FC_VECTOR_OFFSET 32'h0000_0100

// Prefetch buffer entries
`define FC_FETCH_DEPTH 2

`endif

/* hw/fc_subsystem.sv */
// ****************************
// Fabric controller subsystem
// Interrupt capture, fetch and execute on two L2 ports
// ****************************
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_subsystem
  import fc_isa_pkg::*, fc_irq_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_en_i,
  input  logic [`FC_XLEN-1:0]    boot_addr_i,
  input  logic                   debug_req_i,
  input  logic [`FC_NUM_IRQ-1:0] events_i,
  output logic                   core_irq_ack_o,
  output fc_irq_id_t             core_irq_ack_id_o,
  output logic                   stoptimer_o,

  // L2 instruction port
  output logic                   l2_instr_req_o,
  output logic [`FC_XLEN-1:0]    l2_instr_addr_o,
  input  logic                   l2_instr_gnt_i,
  input  logic                   l2_instr_rvalid_i,
  input  logic [`FC_XLEN-1:0]    l2_instr_rdata_i,

  // L2 data port
  output logic                   l2_data_req_o,
  output logic [`FC_XLEN-1:0]    l2_data_addr_o,
  output logic                   l2_data_we_o,
  output logic [`FC_XLEN-1:0]    l2_data_wdata_o,
  input  logic                   l2_data_gnt_i,
  input  logic                   l2_data_rvalid_i,
  input  logic [`FC_XLEN-1:0]    l2_data_rdata_i
);

  logic [`FC_NUM_IRQ-1:0] irq_pending;
  logic                   instr_valid;
  fc_instr_t              instr_word;
  logic [`FC_XLEN-1:0]    instr_pc;
  logic                   instr_take;
  logic                   redirect;
  logic [`FC_XLEN-1:0]    redirect_pc;
  logic                   fetch_stall;
  logic                   start;
  logic [`FC_XLEN-1:0]    start_pc;

  // ****************************
  // Interrupt capture
  // ****************************
  fc_irq_capture irq_capture_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .events_i     (events_i),
    .irq_ack_i    (core_irq_ack_o),
    .irq_ack_id_i (core_irq_ack_id_o),
    .irq_pending_o(irq_pending)
  );

  // ****************************
  // Core pipeline
  // ****************************
  fc_fetch fetch_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .start_i          (start),
    .start_pc_i       (start_pc),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .stall_i          (fetch_stall),
    .instr_take_i     (instr_take),
    .instr_valid_o    (instr_valid),
    .instr_word_o     (instr_word),
    .instr_pc_o       (instr_pc),
    .l2_instr_req_o   (l2_instr_req_o),
    .l2_instr_addr_o  (l2_instr_addr_o),
    .l2_instr_gnt_i   (l2_instr_gnt_i),
    .l2_instr_rvalid_i(l2_instr_rvalid_i),
    .l2_instr_rdata_i (l2_instr_rdata_i)
  );

  fc_execute execute_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_en_i      (fetch_en_i),
    .boot_addr_i     (boot_addr_i),
    .debug_req_i     (debug_req_i),
    .irq_pending_i   (irq_pending),
    .instr_valid_i   (instr_valid),
    .instr_word_i    (instr_word),
    .instr_pc_i      (instr_pc),
    .instr_take_o    (instr_take),
    .redirect_o      (redirect),
    .redirect_pc_o   (redirect_pc),
    .fetch_stall_o   (fetch_stall),
    .start_o         (start),
    .start_pc_o      (start_pc),
    .irq_ack_o       (core_irq_ack_o),
    .irq_ack_id_o    (core_irq_ack_id_o),
    .stoptimer_o     (stoptimer_o),
    .l2_data_req_o   (l2_data_req_o),
    .l2_data_addr_o  (l2_data_addr_o),
    .l2_data_we_o    (l2_data_we_o),
    .l2_data_wdata_o (l2_data_wdata_o),
    .l2_data_gnt_i   (l2_data_gnt_i),
    .l2_data_rvalid_i(l2_data_rvalid_i),
    .l2_data_rdata_i (l2_data_rdata_i)
  );

endmodule

/* verification/fc_stimulus.txt */
# M byte_addr word      : program and data image
# E stores delay mask   : after that many stores and delay cycles, drive events_i
# D stores delay hold   : raise debug, hold it for hold cycles after stoptimer rises
# S byte_addr data      : expected store, in order
# A id                  : expected acknowledge id, in order
M 000 10000011
M 004 40000200
M 008 20000001
M 00C 30000201
M 010 20000002
M 014 40000202
M 018 60000000
M 01C 10000033
M 020 40000203
M 024 60000000
M 028 10000044
M 02C 40000204
M 030 60000000
M 034 10000066
M 038 40000205
M 03C 10000077
M 040 40000206
M 044 20000001
M 048 40000207
M 04C 50000013
# Vectors and handlers
M 10C 50000060
M 114 10000055
M 118 40000210
M 11C 70000000
M 124 50000068
M 12C 1000000B
M 130 40000218
M 134 00000000
M 138 00000000
M 13C 00000000
M 140 00000000
M 144 70000000
M 150 10000014
M 154 40000219
M 158 70000000
M 180 10000003
M 184 40000214
M 188 70000000
M 1A0 10000009
M 1A4 40000215
M 1A8 70000000
M 804 00000040
E 2 20 00000020
E 4 20 00000228
E 7 20 00100A28
E 9 0 00100228
D 11 0 0000001E
S 800 00000011
S 808 00000042
S 840 00000055
S 80C 00000033
S 850 00000003
S 854 00000009
S 810 00000044
S 860 0000000B
S 860 0000000B
S 864 00000014
S 814 00000066
S 818 00000077
S 81C 00000078
A 05
A 03
A 09
A 0B
A 0B
A 14

/* verification/tb_clk_gen.sv */
// ****************************
// Testbench clock and reset
// 10 ns clock, reset low for three cycles
// ****************************
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset released on the third rising edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* verification/tb_fc_subsystem.sv */
// ****************************
// Fabric controller subsystem testbench
// L2 memory model with random delays, event and debug schedule
// ****************************
`timescale 1ns/1ps
`include "fc_settings.svh"

module tb_fc_subsystem;

  localparam int WAIT_LIMIT = 3000;
  localparam int ID_W = $clog2(`FC_NUM_IRQ);

  logic clk, rst_n;
  logic fetch_en, debug_req, irq_ack, stoptimer;
  logic [`FC_XLEN-1:0] boot_addr;
  logic [`FC_NUM_IRQ-1:0] events;
  logic [ID_W-1:0] irq_ack_id;
  logic i_req, i_gnt, i_rvalid, d_req, d_we, d_gnt, d_rvalid;
  logic [`FC_XLEN-1:0] i_addr, i_rdata, d_addr, d_wdata, d_rdata;

  logic [31:0] mem [0:1023];
  logic [31:0] i_rng = 32'h1174;
  logic [31:0] d_rng = 32'h1174 ^ 32'hffff_ffff;
  logic        i_armed, d_armed;
  int          i_gnt_wait, i_rsp_cnt, d_gnt_wait, d_rsp_cnt;
  logic [31:0] i_rsp_addr, d_rsp_addr;
  int          store_count;

  // Schedule and expected records from the stimulus file
  bit          sched_debug [$];
  int          sched_count [$];
  int          sched_delay [$];
  logic [31:0] sched_value [$];
  logic [31:0] exp_store_addr [$];
  logic [31:0] exp_store_data [$];
  logic [31:0] exp_ack [$];

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  fc_subsystem dut_i (
    .clk_i(clk), .rst_ni(rst_n), .fetch_en_i(fetch_en), .boot_addr_i(boot_addr),
    .debug_req_i(debug_req), .events_i(events), .core_irq_ack_o(irq_ack),
    .core_irq_ack_id_o(irq_ack_id), .stoptimer_o(stoptimer),
    .l2_instr_req_o(i_req), .l2_instr_addr_o(i_addr), .l2_instr_gnt_i(i_gnt),
    .l2_instr_rvalid_i(i_rvalid), .l2_instr_rdata_i(i_rdata),
    .l2_data_req_o(d_req), .l2_data_addr_o(d_addr), .l2_data_we_o(d_we),
    .l2_data_wdata_o(d_wdata), .l2_data_gnt_i(d_gnt), .l2_data_rvalid_i(d_rvalid),
    .l2_data_rdata_i(d_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic wait_for_stores(input int count);
    int cycles;
    cycles = 0;
    while (store_count < count) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure($sformatf("store number %0d never appeared", count));
      end
    end
  endtask

  task automatic wait_for_stoptimer(input logic level);
    int cycles;
    cycles = 0;
    while (stoptimer !== level) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure($sformatf("stoptimer_o never went to %0b", level));
      end
    end
  endtask

  task automatic read_stimulus();
    int          fd;
    string       line;
    string       tag;
    int          cnt;
    int          dly;
    logic [31:0] a;
    logic [31:0] w;
    fd = $fopen("verification/fc_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verification/fc_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      void'($sscanf(line, "%s", tag));
      if (tag == "M") begin
        void'($sscanf(line, "%s %h %h", tag, a, w));
        mem[a[11:2]] = w;
      end else if (tag == "E" || tag == "D") begin
        void'($sscanf(line, "%s %d %d %h", tag, cnt, dly, w));
        sched_debug.push_back(tag == "D");
        sched_count.push_back(cnt);
        sched_delay.push_back(dly);
        sched_value.push_back(w);
      end else if (tag == "S") begin
        void'($sscanf(line, "%s %h %h", tag, a, w));
        exp_store_addr.push_back(a);
        exp_store_data.push_back(w);
      end else if (tag == "A") begin
        void'($sscanf(line, "%s %h", tag, a));
        exp_ack.push_back(a);
      end
    end
    $fclose(fd);
  endtask

  // ****************************
  // L2 instruction port model
  // ****************************
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      i_gnt     <= 1'b0;
      i_rvalid  <= 1'b0;
      i_armed   <= 1'b0;
      i_rsp_cnt <= 0;
    end else begin
      i_gnt    <= 1'b0;
      i_rvalid <= 1'b0;
      if (i_req && i_gnt) begin
        i_rng = xorshift(i_rng);
        i_armed    <= 1'b0;
        i_rsp_addr <= i_addr;
        if (i_rng % 3 == 0) begin
          i_rvalid <= 1'b1;
          i_rdata  <= mem[i_addr[11:2]];
        end else begin
          i_rsp_cnt <= i_rng % 3;
        end
      end else if (i_req) begin
        if (!i_armed) begin
          i_rng = xorshift(i_rng);
          i_armed    <= 1'b1;
          i_gnt_wait <= i_rng % 4;
        end else if (i_gnt_wait == 0) begin
          i_gnt <= 1'b1;
        end else begin
          i_gnt_wait <= i_gnt_wait - 1;
        end
      end
      if (i_rsp_cnt == 1) begin
        i_rvalid <= 1'b1;
        i_rdata  <= mem[i_rsp_addr[11:2]];
      end
      if (i_rsp_cnt != 0) begin
        i_rsp_cnt <= i_rsp_cnt - 1;
      end
    end
  end

  // ****************************
  // L2 data port model
  // ****************************
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_gnt       <= 1'b0;
      d_rvalid    <= 1'b0;
      d_armed     <= 1'b0;
      d_rsp_cnt   <= 0;
      store_count <= 0;
    end else begin
      d_gnt    <= 1'b0;
      d_rvalid <= 1'b0;
      if (d_req && d_gnt) begin
        d_rng = xorshift(d_rng);
        d_armed    <= 1'b0;
        d_rsp_addr <= d_addr;
        if (d_we) begin
          if (debug_req === 1'b1) begin
            report_failure("store issued while debug_req_i is high");
          end
          if (exp_store_addr.size() == 0) begin
            report_failure("store seen after the last expected one");
          end
          check_value("l2_data_addr_o", d_addr, exp_store_addr[0]);
          check_value("l2_data_wdata_o", d_wdata, exp_store_data[0]);
          exp_store_addr.delete(0);
          exp_store_data.delete(0);
          mem[d_addr[11:2]] <= d_wdata;
          store_count <= store_count + 1;
        end
        if (d_rng % 3 == 0) begin
          d_rvalid <= 1'b1;
          d_rdata  <= mem[d_addr[11:2]];
        end else begin
          d_rsp_cnt <= d_rng % 3;
        end
      end else if (d_req) begin
        if (!d_armed) begin
          d_rng = xorshift(d_rng);
          d_armed    <= 1'b1;
          d_gnt_wait <= d_rng % 4;
        end else if (d_gnt_wait == 0) begin
          d_gnt <= 1'b1;
        end else begin
          d_gnt_wait <= d_gnt_wait - 1;
        end
      end
      if (d_rsp_cnt == 1) begin
        d_rvalid <= 1'b1;
        d_rdata  <= mem[d_rsp_addr[11:2]];
      end
      if (d_rsp_cnt != 0) begin
        d_rsp_cnt <= d_rsp_cnt - 1;
      end
    end
  end

  // Acknowledges must follow the expected id order
  always @(posedge clk) begin
    if (rst_n && irq_ack === 1'b1) begin
      if (exp_ack.size() == 0) begin
        report_failure($sformatf("unexpected acknowledge for id %0d", irq_ack_id));
      end
      check_value("core_irq_ack_id_o", 32'(irq_ack_id), exp_ack[0]);
      exp_ack.delete(0);
    end
  end

  // ****************************
  // Main sequence
  // ****************************
  initial begin
    int cycles;
    int total_stores;
    fetch_en   = 1'b0;
    boot_addr  = '0;
    debug_req  = 1'b0;
    events     = '0;
    i_gnt      = 1'b0;
    i_rvalid   = 1'b0;
    d_gnt      = 1'b0;
    d_rvalid   = 1'b0;
    i_rdata    = '0;
    d_rdata    = '0;
    // Fill pattern for words that the image does not set
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (i << 2);
    end
    read_stimulus();
    total_stores = exp_store_addr.size();

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 20) begin
        report_failure("reset was never released");
      end
    end
    // Quiet outputs before fetch enable
    repeat (5) begin
      @(posedge clk);
      check_value("l2_instr_req_o", 32'(i_req), 32'h0);
      check_value("l2_data_req_o", 32'(d_req), 32'h0);
      check_value("core_irq_ack_o", 32'(irq_ack), 32'h0);
      check_value("stoptimer_o", 32'(stoptimer), 32'h0);
    end
    fetch_en <= 1'b1;

    while (sched_count.size() != 0) begin
      wait_for_stores(sched_count[0]);
      repeat (sched_delay[0]) @(posedge clk);
      if (sched_debug[0]) begin
        debug_req <= 1'b1;
        wait_for_stoptimer(1'b1);
        repeat (sched_value[0]) @(posedge clk);
        debug_req <= 1'b0;
        wait_for_stoptimer(1'b0);
      end else begin
        events <= sched_value[0];
      end
      sched_debug.delete(0);
      sched_count.delete(0);
      sched_delay.delete(0);
      sched_value.delete(0);
    end

    wait_for_stores(total_stores);
    repeat (50) @(posedge clk);
    if (exp_ack.size() != 0) begin
      report_failure($sformatf("%0d expected acknowledges never came", exp_ack.size()));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule
